/* hw/lfo_macros.svh */
// Build-time constants for the LFO block.
// Include wherever the prescaler, phase width or register map is needed.
`ifndef LFO_MACROS_SVH
`define LFO_MACROS_SVH

// clock-enable cycles per oscillator tick
`define LFO_PRESCALE 16

// phase accumulator width
`define LFO_PHASE_W 16

// register byte offsets
`define LFO_REG_FREQ  4'h0
`define LFO_REG_DEPTH 4'h4
`define LFO_REG_CTRL  4'h8
`define LFO_REG_OUT   4'hC

`endif

/* hw/lfo_pkg.sv */
// Shared types for the LFO block.
// Imported by the register decode, the oscillator stages and the testbench.
package lfo_pkg;

    // byte address of the register window
    typedef logic [3:0] lfo_addr_t;

    typedef enum logic [1:0] {
        LFO_SAW    = 2'd0,
        LFO_SQUARE = 2'd1,
        LFO_TRI    = 2'd2,
        LFO_NOISE  = 2'd3
    } lfo_wave_e;

    typedef enum logic [1:0] {
        AXI_OKAY   = 2'b00,
        AXI_EXOKAY = 2'b01,
        AXI_SLVERR = 2'b10,
        AXI_DECERR = 2'b11
    } lfo_resp_e;

    typedef struct packed {
        logic [7:0] freq;
        logic [6:0] amd;
        logic [6:0] pmd;
        lfo_wave_e  wave;
    } lfo_cfg_t;

    // one write byte, seen as depth or control depending on the address
    typedef union packed {
        struct packed {
            logic       pm_sel;
            logic [6:0] depth;
        } depth;
        struct packed {
            logic       restart;
            logic [4:0] rsvd;
            lfo_wave_e  wave;
        } ctrl;
    } lfo_reg_u;

endpackage

/* hw/lfo_cfg_if.sv */
// Configuration bundle from the register decode to the oscillator
// and the depth scaling stage. Decode drives it through the ctrl
// modport; both consumers attach through the user modport.
`timescale 1ns/1ns

interface lfo_cfg_if;
    import lfo_pkg::*;

    // live register contents
    lfo_cfg_t cfg;
    // one-cycle oscillator restart
    logic     restart;

    modport ctrl (
        output cfg,
        output restart
    );

    modport user (
        input cfg,
        input restart
    );

endinterface

/* hw/lfo_reg_decode.sv */
// AXI4-Lite slave for the LFO register map.
// Holds frequency, depths and waveform, issues the restart pulse and
// returns the current am/pm values on reads of the OUT offset.
// One write and one read may be outstanding at a time.
`timescale 1ns/1ns
`include "lfo_macros.svh"

module lfo_reg_decode (
    input  logic               clk,
    input  logic               rst,
    input  logic               awvalid,
    output logic               awready,
    input  lfo_pkg::lfo_addr_t awaddr,
    input  logic               wvalid,
    output logic               wready,
    input  logic [31:0]        wdata,
    input  logic [3:0]         wstrb,
    output logic               bvalid,
    input  logic               bready,
    output lfo_pkg::lfo_resp_e bresp,
    input  logic               arvalid,
    output logic               arready,
    input  lfo_pkg::lfo_addr_t araddr,
    output logic               rvalid,
    input  logic               rready,
    output logic [31:0]        rdata,
    output lfo_pkg::lfo_resp_e rresp,
    input  logic [7:0]         am,
    input  logic signed [7:0]  pm,
    lfo_cfg_if.ctrl            cfg_o
);
    import lfo_pkg::*;

    logic        wr_hs;
    logic        rd_hs;
    logic        wr_map;
    logic        rd_map;
    lfo_reg_u    wr_byte;
    lfo_reg_u    depth_q;
    logic [31:0] rd_word;

    assign wr_hs   = awready && awvalid && wvalid;
    assign rd_hs   = arready && arvalid;
    assign wr_byte = wdata[7:0];

    // OUT is read-only, so it is not a valid write target
    assign wr_map = (awaddr == `LFO_REG_FREQ) || (awaddr == `LFO_REG_DEPTH) ||
                    (awaddr == `LFO_REG_CTRL);
    assign rd_map = (araddr == `LFO_REG_FREQ) || (araddr == `LFO_REG_DEPTH) ||
                    (araddr == `LFO_REG_CTRL) || (araddr == `LFO_REG_OUT);

    always_comb begin
        case (araddr)
            `LFO_REG_FREQ:  rd_word = {24'd0, cfg_o.cfg.freq};
            `LFO_REG_DEPTH: rd_word = {24'd0, depth_q};
            `LFO_REG_CTRL:  rd_word = {24'd0, 6'd0, cfg_o.cfg.wave};
            `LFO_REG_OUT:   rd_word = {16'd0, pm, am};
            default:        rd_word = 32'd0;
        endcase
    end

    // handshake and response state
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= AXI_OKAY;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= AXI_OKAY;
        end else begin
            // ready pulses for a single cycle
            awready <= awvalid && wvalid && !bvalid && !awready;
            wready  <= awvalid && wvalid && !bvalid && !awready;
            arready <= arvalid && !rvalid && !arready;
            if (wr_hs) begin
                bvalid <= 1'b1;
                bresp  <= wr_map ? AXI_OKAY : AXI_SLVERR;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_hs) begin
                rvalid <= 1'b1;
                rresp  <= rd_map ? AXI_OKAY : AXI_SLVERR;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata <= rd_word;
        end
    end

    // register file
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cfg_o.cfg     <= '0;
            cfg_o.restart <= 1'b0;
            depth_q       <= '0;
        end else begin
            cfg_o.restart <= 1'b0;
            if (wr_hs && wstrb[0]) begin
                case (awaddr)
                    `LFO_REG_FREQ: cfg_o.cfg.freq <= wdata[7:0];
                    `LFO_REG_DEPTH: begin
                        depth_q <= wr_byte;
                        // top bit picks which depth is loaded
                        if (wr_byte.depth.pm_sel) begin
                            cfg_o.cfg.pmd <= wr_byte.depth.depth;
                        end else begin
                            cfg_o.cfg.amd <= wr_byte.depth.depth;
                        end
                    end
                    `LFO_REG_CTRL: begin
                        cfg_o.cfg.wave <= wr_byte.ctrl.wave;
                        cfg_o.restart  <= wr_byte.ctrl.restart;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hw/lfo_wave_gen.sv */
// Oscillator core of the LFO.
// A prescaler divides the clock enable down to the oscillator tick.
// Each tick adds the frequency word to the phase accumulator and
// registers the selected waveform. The noise LFSR advances whenever
// the phase wraps.
`timescale 1ns/1ns
`include "lfo_macros.svh"

module lfo_wave_gen (
    input  logic       clk,
    input  logic       rst,
    input  logic       cen,
    lfo_cfg_if.user    cfg_i,
    output logic [7:0] wave_val
);
    import lfo_pkg::*;

    localparam int PW    = `LFO_PHASE_W;
    localparam int PRE_W = $clog2(`LFO_PRESCALE);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;
    logic [PW-1:0]    phase;
    logic [PW-1:0]    phase_nx;
    logic             wrap;
    logic [7:0]       lfsr;
    logic [7:0]       lfsr_nx;
    logic [7:0]       wave_nx;

    assign tick = cen && (pre_cnt == PRE_W'(`LFO_PRESCALE - 1));

    // carry out of the accumulator marks a phase wrap
    assign {wrap, phase_nx} = {1'b0, phase} + (PW + 1)'(cfg_i.cfg.freq);

    // Fibonacci LFSR, taps 8 6 5 4
    assign lfsr_nx = wrap ? {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]} : lfsr;

    always_comb begin
        case (cfg_i.cfg.wave)
            LFO_SAW:    wave_nx = phase_nx[PW-1 -: 8];
            LFO_SQUARE: wave_nx = {8{phase_nx[PW-1]}};
            // second half of the period folds back down
            LFO_TRI:    wave_nx = phase_nx[PW-2 -: 8] ^ {8{phase_nx[PW-1]}};
            default:    wave_nx = lfsr_nx;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pre_cnt  <= '0;
            phase    <= '0;
            lfsr     <= 8'h01;
            wave_val <= 8'd0;
        end else if (cfg_i.restart) begin
            // restart does not wait for the clock enable
            pre_cnt <= '0;
            phase   <= '0;
        end else if (cen) begin
            if (tick) begin
                pre_cnt  <= '0;
                phase    <= phase_nx;
                lfsr     <= lfsr_nx;
                wave_val <= wave_nx;
            end else begin
                pre_cnt <= pre_cnt + 1'b1;
            end
        end
    end

endmodule

/* hw/lfo_depth_scale.sv */
// Result stage of the LFO.
// Scales the waveform by the AM depth into an unsigned value and by the
// PM depth into a signed value centred on zero. Both are registered
// under the clock enable.
`timescale 1ns/1ns

module lfo_depth_scale (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic [7:0]        wave_val,
    lfo_cfg_if.user           cfg_i,
    output logic [7:0]        am,
    output logic signed [7:0] pm
);

    logic [14:0]        am_prod;
    logic [7:0]         am_nx;
    logic signed [7:0]  wave_s;
    logic signed [15:0] pm_prod;
    logic signed [15:0] pm_sh;
    logic signed [7:0]  pm_nx;

    // 8 x 7 bit product, keep the top byte
    assign am_prod = wave_val * cfg_i.cfg.amd;
    assign am_nx   = am_prod[14:7];

    // wave_val - 128 is the same as flipping the msb
    assign wave_s  = $signed({~wave_val[7], wave_val[6:0]});
    assign pm_prod = wave_s * $signed({1'b0, cfg_i.cfg.pmd});
    assign pm_sh   = pm_prod >>> 7;

    // zero depth must give exactly zero
    assign pm_nx = (cfg_i.cfg.pmd == 7'd0) ? 8'sd0 : pm_sh[7:0];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            am <= 8'd0;
            pm <= 8'sd0;
        end else if (cen) begin
            am <= am_nx;
            pm <= pm_nx;
        end
    end

endmodule

/* hw/lfo_top.sv */
// Top level of the LFO block.
// Exposes a plain AXI4-Lite slave for configuration and the am/pm
// modulation outputs. cen qualifies all oscillator and output updates.
`timescale 1ns/1ns

module lfo_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    input  logic              awvalid,
    output logic              awready,
    input  logic [3:0]        awaddr,
    input  logic              wvalid,
    output logic              wready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    output logic              bvalid,
    input  logic              bready,
    output logic [1:0]        bresp,
    input  logic              arvalid,
    output logic              arready,
    input  logic [3:0]        araddr,
    output logic              rvalid,
    input  logic              rready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic [7:0]        am,
    output logic signed [7:0] pm
);

    logic [7:0] wave_val;

    lfo_cfg_if cfg_bus ();

    lfo_reg_decode i_decode (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .am      (am),
        .pm      (pm),
        .cfg_o   (cfg_bus.ctrl)
    );

    lfo_wave_gen i_wave (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .cfg_i    (cfg_bus.user),
        .wave_val (wave_val)
    );

    // outputs loop back to decode for the OUT readback
    lfo_depth_scale i_scale (
        .clk      (clk),
        .rst      (rst),
        .cen      (cen),
        .wave_val (wave_val),
        .cfg_i    (cfg_bus.user),
        .am       (am),
        .pm       (pm)
    );

endmodule

/* dv/lfo_sva.sv */
// Bus handshake and output rules of the LFO block.
// Bound to lfo_top from the testbench; reports through failing assertions.
`timescale 1ns/1ns

module lfo_sva (
    input logic              clk,
    input logic              rst,
    input logic              cen,
    input logic              awvalid,
    input logic              awready,
    input logic              wvalid,
    input logic              wready,
    input logic              bvalid,
    input logic              bready,
    input logic              arvalid,
    input logic              arready,
    input logic              rvalid,
    input logic              rready,
    input logic [7:0]        am,
    input logic signed [7:0] pm
);

    int n_fail = 0;

    // responses stay up until the master takes them
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else begin
            n_fail++;
            $error("bvalid dropped before bready");
        end

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid)
        else begin
            n_fail++;
            $error("rvalid dropped before rready");
        end

    // nothing new is accepted behind a pending response
    a_no_write_pending: assert property (@(posedge clk) disable iff (rst)
        bvalid |-> !(awready && awvalid && wvalid))
        else begin
            n_fail++;
            $error("write accepted while a write response is pending");
        end

    a_no_read_pending: assert property (@(posedge clk) disable iff (rst)
        rvalid |-> !(arready && arvalid))
        else begin
            n_fail++;
            $error("read accepted while a read response is pending");
        end

    a_aw_w_paired: assert property (@(posedge clk) disable iff (rst)
        awready == wready)
        else begin
            n_fail++;
            $error("awready and wready differ");
        end

    a_reset_idle: assert property (@(posedge clk)
        $past(rst) |-> !awready && !wready && !bvalid && !rvalid)
        else begin
            n_fail++;
            $error("bus handshake active right after reset");
        end

    // results only move on enabled cycles
    a_hold_without_cen: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(am) && $stable(pm))
        else begin
            n_fail++;
            $error("am or pm changed with cen low");
        end

endmodule

/* dv/lfo_tb.sv */
// Testbench for the LFO block.
// Drives seeded random AXI4-Lite traffic with random response stalls and
// a random clock enable, then a long run at the top rate through every
// waveform. Checks every bus response and the am/pm ports against a
// cycle-level reference model of the oscillator and scaling.
`timescale 1ns/1ns
`include "lfo_macros.svh"

module lfo_tb;
    import lfo_pkg::*;

    localparam int N_TRANS    = 200;
    localparam int SWEEP_SEGS = 8;
    // cycles spent on each waveform in the long run
    localparam int SWEEP_LEN  = 1024;
    localparam int MAX_CYCLES = N_TRANS * 40 + SWEEP_SEGS * (SWEEP_LEN + 40);

    logic              clk;
    logic              rst;
    logic              cen;
    logic              awvalid;
    logic              awready;
    logic [3:0]        awaddr;
    logic              wvalid;
    logic              wready;
    logic [31:0]       wdata;
    logic [3:0]        wstrb;
    logic              bvalid;
    logic              bready;
    logic [1:0]        bresp;
    logic              arvalid;
    logic              arready;
    logic [3:0]        araddr;
    logic              rvalid;
    logic              rready;
    logic [31:0]       rdata;
    logic [1:0]        rresp;
    logic [7:0]        am;
    logic signed [7:0] pm;

    integer seed;
    int     cycles;
    int     errors;

    // reference model state
    lfo_cfg_t                m_cfg;
    logic                    m_restart;
    lfo_reg_u                m_depth;
    lfo_reg_u                m_byte;
    int                      m_pre;
    logic [`LFO_PHASE_W-1:0] m_phase;
    logic [`LFO_PHASE_W:0]   m_sum;
    logic [7:0]              m_lfsr;
    logic [7:0]              m_wave;
    logic [7:0]              m_am;
    logic signed [7:0]       m_pm;

    // write that lands on the coming rising edge
    logic       wr_pend;
    logic [3:0] wr_addr;
    logic [7:0] wr_data;
    logic       wr_en;

    lfo_top i_dut (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .am      (am),
        .pm      (pm)
    );

    bind lfo_top lfo_sva i_sva (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .awvalid (awvalid),
        .awready (awready),
        .wvalid  (wvalid),
        .wready  (wready),
        .bvalid  (bvalid),
        .bready  (bready),
        .arvalid (arvalid),
        .arready (arready),
        .rvalid  (rvalid),
        .rready  (rready),
        .am      (am),
        .pm      (pm)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Simulation FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        errors = errors + 1;
        $display("FAILED at %0t ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic check_bresp(input lfo_resp_e got, input lfo_resp_e exp);
        if (got !== exp) begin
            report_error($sformatf("bresp %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic check_rresp(input lfo_resp_e got, input lfo_resp_e exp);
        if (got !== exp) begin
            report_error($sformatf("rresp %s, expected %s", got.name(), exp.name()));
        end
    endtask

    task automatic check_rdata(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            report_error($sformatf("rdata 0x%08h, expected 0x%08h", got, exp));
        end
    endtask

    task automatic check_out(input logic [7:0] am_got, input logic signed [7:0] pm_got,
                             input logic [7:0] am_exp, input logic signed [7:0] pm_exp);
        if (am_got !== am_exp || pm_got !== pm_exp) begin
            report_error($sformatf("am %0d pm %0d, expected am %0d pm %0d",
                                   am_got, pm_got, am_exp, pm_exp));
        end
    endtask

    function automatic logic [7:0] scale_am(input logic [7:0] w, input logic [6:0] d);
        int p;
        p = int'(w) * int'(d);
        return 8'(p >> 7);
    endfunction

    function automatic logic signed [7:0] scale_pm(input logic [7:0] w, input logic [6:0] d);
        int p;
        if (d == 7'd0) begin
            return 8'sd0;
        end
        p = (int'(w) - 128) * int'(d);
        p = p >>> 7;
        return 8'(p);
    endfunction

    function automatic logic [7:0] wave_of(input lfo_wave_e w, input logic [15:0] ph,
                                           input logic [7:0] rnd);
        case (w)
            LFO_SAW:    return ph[15:8];
            LFO_SQUARE: return ph[15] ? 8'hFF : 8'h00;
            LFO_TRI:    return ph[15] ? ~ph[14:7] : ph[14:7];
            default:    return rnd;
        endcase
    endfunction

    function automatic logic writable(input logic [3:0] a);
        return a == `LFO_REG_FREQ || a == `LFO_REG_DEPTH || a == `LFO_REG_CTRL;
    endfunction

    function automatic logic [31:0] expect_rdata(input logic [3:0] a);
        case (a)
            `LFO_REG_FREQ:  return {24'd0, m_cfg.freq};
            `LFO_REG_DEPTH: return {24'd0, m_depth};
            `LFO_REG_CTRL:  return {30'd0, m_cfg.wave};
            `LFO_REG_OUT:   return {16'd0, m_pm, m_am};
            default:        return 32'd0;
        endcase
    endfunction

    // reference model, one step per rising edge
    always @(posedge clk) begin
        if (rst) begin
            m_cfg     = '0;
            m_restart = 1'b0;
            m_depth   = '0;
            m_pre     = 0;
            m_phase   = '0;
            m_lfsr    = 8'h01;
            m_wave    = 8'd0;
            m_am      = 8'd0;
            m_pm      = 8'sd0;
            wr_pend   = 1'b0;
        end else begin
            // outputs follow the waveform and depths of the previous cycle
            if (cen) begin
                m_am = scale_am(m_wave, m_cfg.amd);
                m_pm = scale_pm(m_wave, m_cfg.pmd);
            end
            if (m_restart) begin
                m_pre   = 0;
                m_phase = '0;
            end else if (cen) begin
                if (m_pre == `LFO_PRESCALE - 1) begin
                    m_pre   = 0;
                    m_sum   = {1'b0, m_phase} + m_cfg.freq;
                    m_phase = m_sum[`LFO_PHASE_W-1:0];
                    if (m_sum[`LFO_PHASE_W]) begin
                        m_lfsr = {m_lfsr[6:0], m_lfsr[7] ^ m_lfsr[5] ^ m_lfsr[4] ^ m_lfsr[3]};
                    end
                    m_wave = wave_of(m_cfg.wave, m_phase, m_lfsr);
                end else begin
                    m_pre = m_pre + 1;
                end
            end
            m_restart = 1'b0;
            if (wr_pend) begin
                wr_pend = 1'b0;
                m_byte  = wr_data;
                if (wr_en && wr_addr == `LFO_REG_FREQ) begin
                    m_cfg.freq = wr_data;
                end else if (wr_en && wr_addr == `LFO_REG_DEPTH) begin
                    m_depth = m_byte;
                    if (m_byte.depth.pm_sel) begin
                        m_cfg.pmd = m_byte.depth.depth;
                    end else begin
                        m_cfg.amd = m_byte.depth.depth;
                    end
                end else if (wr_en && wr_addr == `LFO_REG_CTRL) begin
                    m_cfg.wave = m_byte.ctrl.wave;
                    m_restart  = m_byte.ctrl.restart;
                end
            end
        end
    end

    // outputs are compared every cycle once reset is released
    always @(negedge clk) begin
        if (i_dut.i_sva.n_fail != 0) begin
            $display("a bus handshake or output assertion failed");
            $display("Simulation FAILED");
            $fatal(1, "stopped at the first assertion failure");
        end else if (!rst) begin
            check_out(am, pm, m_am, m_pm);
        end
    end

    task automatic next_cycle();
        @(negedge clk);
        cen = ($random(seed) & 3) != 0;
    endtask

    task automatic write_reg(input logic [3:0] addr, input logic [7:0] data,
                             input logic [3:0] strb);
        lfo_resp_e exp;
        exp     = writable(addr) ? AXI_OKAY : AXI_SLVERR;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        awaddr  = addr;
        wdata   = $random(seed);
        wdata[7:0] = data;
        wstrb   = strb;
        next_cycle();
        while (!awready) next_cycle();
        wr_addr = addr;
        wr_data = data;
        wr_en   = strb[0] && writable(addr);
        wr_pend = 1'b1;
        next_cycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = ($random(seed) & 1) != 0;
        while (!(bvalid && bready)) begin
            next_cycle();
            bready = ($random(seed) & 1) != 0;
        end
        check_bresp(lfo_resp_e'(bresp), exp);
        next_cycle();
        bready = 1'b0;
    endtask

    task automatic read_reg(input logic [3:0] addr);
        lfo_resp_e   exp_resp;
        logic [31:0] exp_data;
        arvalid = 1'b1;
        araddr  = addr;
        next_cycle();
        while (!arready) next_cycle();
        // data is taken from this cycle's state at the coming edge
        exp_resp = (writable(addr) || addr == `LFO_REG_OUT) ? AXI_OKAY : AXI_SLVERR;
        exp_data = expect_rdata(addr);
        next_cycle();
        arvalid = 1'b0;
        rready  = ($random(seed) & 1) != 0;
        while (!(rvalid && rready)) begin
            next_cycle();
            rready = ($random(seed) & 1) != 0;
        end
        check_rresp(lfo_resp_e'(rresp), exp_resp);
        check_rdata(rdata, exp_data);
        next_cycle();
        rready = 1'b0;
    endtask

    // mostly mapped offsets, sometimes any 4-bit address
    task automatic pick_addr(output logic [3:0] a);
        int r;
        r = $random(seed) & 7;
        if (r < 6) begin
            a = 4'((r % 4) * 4);
        end else begin
            a = 4'($random(seed));
        end
    endtask

    initial begin
        logic [3:0] addr;
        logic [7:0] data;
        logic [3:0] strb;
        int         idle;
        int         i;
        seed    = 75410;
        cycles  = 0;
        errors  = 0;
        rst     = 1'b1;
        cen     = 1'b0;
        awvalid = 1'b0;
        awaddr  = 4'd0;
        wvalid  = 1'b0;
        wdata   = 32'd0;
        wstrb   = 4'd0;
        bready  = 1'b0;
        arvalid = 1'b0;
        araddr  = 4'd0;
        rready  = 1'b0;
        wr_pend = 1'b0;
        wr_addr = 4'd0;
        wr_data = 8'd0;
        wr_en   = 1'b0;
        repeat (10) next_cycle();
        rst = 1'b0;
        for (i = 0; i < N_TRANS; i++) begin
            pick_addr(addr);
            data = $random(seed);
            strb = (($random(seed) & 7) == 0) ? 4'hE : 4'hF;
            if (($random(seed) % 5) < 3) begin
                write_reg(addr, data, strb);
            end else begin
                read_reg(addr);
            end
            idle = $random(seed) & 7;
            repeat (idle) next_cycle();
        end
        // long run at the top rate so the phase wraps and every waveform
        // sees both halves of the period
        write_reg(`LFO_REG_FREQ, 8'hFF, 4'hF);
        write_reg(`LFO_REG_DEPTH, 8'h7F, 4'hF);
        write_reg(`LFO_REG_DEPTH, 8'hFF, 4'hF);
        for (i = 0; i < SWEEP_SEGS; i++) begin
            write_reg(`LFO_REG_CTRL, 8'(i % 4), 4'hF);
            repeat (SWEEP_LEN) next_cycle();
        end
        repeat (20) next_cycle();
        if (errors == 0 && i_dut.i_sva.n_fail == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* lfo_top.f */
+incdir+hw
hw/lfo_pkg.sv
hw/lfo_cfg_if.sv
hw/lfo_reg_decode.sv
hw/lfo_wave_gen.sv
hw/lfo_depth_scale.sv
hw/lfo_top.sv
dv/lfo_sva.sv
dv/lfo_tb.sv

/* Bender.yml */
package:
  name: lfo

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/lfo_pkg.sv
      - hw/lfo_cfg_if.sv
      - hw/lfo_reg_decode.sv
      - hw/lfo_wave_gen.sv
      - hw/lfo_depth_scale.sv
      - hw/lfo_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/lfo_sva.sv
      - dv/lfo_tb.sv
